// ==== hw/cpu_pkg.sv ====
/*
 * CPU shared definitions
 * Widths, opcode/ALU/state encodings, the datapath control bundle
 * and the memory request struct used on both bus ports
 */
`default_nettype none

package cpu_pkg;

	localparam int XLEN = 32; // Fixed by RV32I
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// Kept major opcodes
	typedef enum logic [6:0] {
		OP_ALU_R = 7'b0110011,
		OP_ALU_I = 7'b0010011,
		OP_LOAD = 7'b0000011,
		OP_STORE = 7'b0100011,
		OP_LUI = 7'b0110111,
		OP_BRANCH = 7'b1100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic [2:0] {
		ST_RESET,
		ST_FETCH,
		ST_DECODE,
		ST_EXECUTE,
		ST_MEMORY,
		ST_WRITEBACK
	} state_e;

	typedef enum logic [1:0] {
		WB_RESULT,
		WB_LOAD,
		WB_UPPER
	} wb_src_e;

	// Compare results of the last subtraction
	typedef struct packed {
		logic eq;
		logic lt; // Signed
		logic ltu; // Unsigned
	} flags_t;

	typedef struct packed {
		reg_addr_t rs1_addr;
		reg_addr_t rs2_addr;
		reg_addr_t rd_addr;
		logic load_operands; // Latch A and B
		logic rf_write;
		wb_src_e wb_src;
		logic use_imm; // Immediate as second ALU operand
		alu_op_e alu_op;
		logic load_result; // Result and flags
		logic load_store_data;
		logic pc_advance;
		word_t imm; // Operand, branch offset or upper immediate
	} dp_ctrl_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic rd;
		logic wr;
	} mem_req_t;

endpackage

`default_nettype wire

// ==== hw/reg_file.sv ====
/*
 * Register file
 * 32 words with x0 fixed at zero, writeback source select
 * and the latched operand registers A and B
 */
`default_nettype none

module reg_file (
	input wire clk,
	input wire reset,
	input wire cpu_pkg::dp_ctrl_t i_ctrl,
	input wire cpu_pkg::word_t i_result,
	input wire cpu_pkg::word_t i_load_data,
	output cpu_pkg::word_t o_op_a,
	output cpu_pkg::word_t o_op_b
);
	cpu_pkg::word_t regs [32];
	cpu_pkg::word_t wr_data;

	always_comb begin
		case (i_ctrl.wb_src)
			cpu_pkg::WB_LOAD: wr_data = i_load_data;
			cpu_pkg::WB_UPPER: wr_data = i_ctrl.imm; // lui
			default: wr_data = i_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_ctrl.rf_write && i_ctrl.rd_addr != '0) begin // x0 stays zero
			regs[i_ctrl.rd_addr] <= wr_data;
		end
	end

	// Operand registers A and B
	always_ff @(posedge clk) begin
		if (i_ctrl.load_operands) begin
			o_op_a <= regs[i_ctrl.rs1_addr];
			o_op_b <= regs[i_ctrl.rs2_addr];
		end
	end

endmodule

`default_nettype wire

// ==== hw/execute_unit.sv ====
/*
 * Execute unit
 * Operand select and ALU, registered result with compare flags,
 * and the store-data register
 */
`default_nettype none

module execute_unit (
	input wire clk,
	input wire reset,
	input wire cpu_pkg::dp_ctrl_t i_ctrl,
	input wire cpu_pkg::word_t i_op_a,
	input wire cpu_pkg::word_t i_op_b,
	output cpu_pkg::word_t o_result,
	output cpu_pkg::flags_t o_flags,
	output cpu_pkg::word_t o_store_data
);
	cpu_pkg::word_t op2;
	cpu_pkg::word_t alu_out;
	cpu_pkg::flags_t flags_d;
	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;

	assign op2 = i_ctrl.use_imm ? i_ctrl.imm : i_op_b;
	assign shamt = op2[4:0]; // Low five bits only
	assign lt_s = $signed(i_op_a) < $signed(op2);
	assign lt_u = i_op_a < op2;

	always_comb begin
		case (i_ctrl.alu_op)
			cpu_pkg::ALU_SUB: alu_out = i_op_a - op2;
			cpu_pkg::ALU_SLL: alu_out = i_op_a << shamt;
			cpu_pkg::ALU_SLT: alu_out = {{(cpu_pkg::XLEN-1){1'b0}}, lt_s};
			cpu_pkg::ALU_SLTU: alu_out = {{(cpu_pkg::XLEN-1){1'b0}}, lt_u};
			cpu_pkg::ALU_XOR: alu_out = i_op_a ^ op2;
			cpu_pkg::ALU_SRL: alu_out = i_op_a >> shamt;
			cpu_pkg::ALU_SRA: alu_out = cpu_pkg::word_t'($signed(i_op_a) >>> shamt);
			cpu_pkg::ALU_OR: alu_out = i_op_a | op2;
			cpu_pkg::ALU_AND: alu_out = i_op_a & op2;
			default: alu_out = i_op_a + op2; // add
		endcase
	end

	// Flags for the branch rule in control
	assign flags_d.eq = (i_op_a == op2);
	assign flags_d.lt = lt_s;
	assign flags_d.ltu = lt_u;

	always_ff @(posedge clk) begin
		if (reset) begin
			o_result <= '0;
			o_flags <= '0;
		end else if (i_ctrl.load_result) begin
			o_result <= alu_out;
			o_flags <= flags_d;
		end
	end

	always_ff @(posedge clk) begin
		if (i_ctrl.load_store_data) begin
			o_store_data <= i_op_b; // Always B, never the immediate
		end
	end

endmodule

`default_nettype wire

// ==== hw/pc_unit.sv ====
/*
 * Program counter
 * Steps by 4 or by the branch offset when control says taken
 */
`default_nettype none

module pc_unit #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
)(
	input wire clk,
	input wire reset,
	input wire cpu_pkg::dp_ctrl_t i_ctrl,
	input wire i_branch_taken,
	output cpu_pkg::word_t o_pc
);
	cpu_pkg::word_t step;

	assign step = i_branch_taken ? i_ctrl.imm : 32'd4; // B-format offset when taken

	always_ff @(posedge clk) begin
		if (reset) begin
			o_pc <= RESET_PC;
		end else if (i_ctrl.pc_advance) begin
			o_pc <= o_pc + step;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cpu_control.sv ====
/*
 * CPU control unit
 * Instruction register, immediate decode, ALU op mapping,
 * branch condition and the FSM driving every datapath control
 */
`default_nettype none

module cpu_control (
	input wire clk,
	input wire reset,
	input wire cpu_pkg::word_t i_fetch_rdata,
	input wire cpu_pkg::word_t i_ldst_rdata,
	input wire cpu_pkg::flags_t i_flags,

	output cpu_pkg::dp_ctrl_t o_ctrl,
	output logic o_fetch_rd,
	output logic o_ldst_rd,
	output logic o_ldst_wr,
	output cpu_pkg::word_t o_load_data,
	output logic o_branch_taken
);
	cpu_pkg::state_e state, state_next;
	cpu_pkg::word_t instr_q; // Instruction register
	cpu_pkg::word_t imm_q; // Decoded immediate
	cpu_pkg::word_t cur_instr;
	cpu_pkg::opcode_e opcode;
	cpu_pkg::alu_op_e alu_op;
	logic [2:0] funct3;
	logic funct7_alt; // Bit 30 selects sub and sra
	logic cond_true;

	function automatic cpu_pkg::word_t decode_imm(input cpu_pkg::word_t instr);
		case (cpu_pkg::opcode_e'(instr[6:0]))
			cpu_pkg::OP_STORE: decode_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			cpu_pkg::OP_BRANCH: decode_imm = {{20{instr[31]}}, instr[7], instr[30:25],
				instr[11:8], 1'b0};
			cpu_pkg::OP_LUI: decode_imm = {instr[31:12], 12'h000};
			default: decode_imm = {{20{instr[31]}}, instr[31:20]}; // I format
		endcase
	endfunction

	// Fetched word is live during decode, IR afterwards
	assign cur_instr = (state == cpu_pkg::ST_DECODE) ? i_fetch_rdata : instr_q;
	assign opcode = cpu_pkg::opcode_e'(cur_instr[6:0]);
	assign funct3 = cur_instr[14:12];
	assign funct7_alt = cur_instr[30];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cpu_pkg::ST_RESET;
			instr_q <= '0;
		end else begin
			state <= state_next;
			if (state == cpu_pkg::ST_DECODE) begin
				instr_q <= i_fetch_rdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == cpu_pkg::ST_DECODE) begin
			imm_q <= decode_imm(i_fetch_rdata);
		end
	end

	// funct3/funct7 to ALU operation
	always_comb begin
		case (funct3)
			3'b000: alu_op = (opcode == cpu_pkg::OP_ALU_R && funct7_alt) ?
				cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
			3'b001: alu_op = cpu_pkg::ALU_SLL;
			3'b010: alu_op = cpu_pkg::ALU_SLT;
			3'b011: alu_op = cpu_pkg::ALU_SLTU;
			3'b100: alu_op = cpu_pkg::ALU_XOR;
			3'b101: alu_op = funct7_alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
			3'b110: alu_op = cpu_pkg::ALU_OR;
			default: alu_op = cpu_pkg::ALU_AND;
		endcase
	end

	// Branch rule from the registered flags
	always_comb begin
		case (funct3)
			3'b000: cond_true = i_flags.eq; // beq
			3'b001: cond_true = !i_flags.eq; // bne
			3'b100: cond_true = i_flags.lt; // blt
			3'b101: cond_true = !i_flags.lt; // bge
			3'b110: cond_true = i_flags.ltu; // bltu
			3'b111: cond_true = !i_flags.ltu; // bgeu
			default: cond_true = 1'b0;
		endcase
	end

	// Read data is valid in writeback, one cycle after the rd strobe
	assign o_load_data = i_ldst_rdata;

	always_comb begin
		o_ctrl = '0;
		o_ctrl.rs1_addr = cur_instr[19:15];
		o_ctrl.rs2_addr = cur_instr[24:20];
		o_ctrl.rd_addr = cur_instr[11:7];
		o_ctrl.wb_src = cpu_pkg::WB_RESULT;
		o_ctrl.alu_op = alu_op;
		o_ctrl.imm = (state == cpu_pkg::ST_DECODE) ? decode_imm(i_fetch_rdata) : imm_q;
		o_fetch_rd = 1'b0;
		o_ldst_rd = 1'b0;
		o_ldst_wr = 1'b0;
		o_branch_taken = 1'b0;
		state_next = cpu_pkg::ST_FETCH;

		case (state)
			cpu_pkg::ST_RESET: state_next = cpu_pkg::ST_FETCH;
			cpu_pkg::ST_FETCH: begin
				o_fetch_rd = 1'b1;
				state_next = cpu_pkg::ST_DECODE;
			end
			cpu_pkg::ST_DECODE: begin
				case (opcode)
					cpu_pkg::OP_LUI: begin // Done in one step
						o_ctrl.rf_write = 1'b1;
						o_ctrl.wb_src = cpu_pkg::WB_UPPER;
						o_ctrl.pc_advance = 1'b1;
					end
					cpu_pkg::OP_ALU_R, cpu_pkg::OP_ALU_I, cpu_pkg::OP_LOAD,
					cpu_pkg::OP_STORE, cpu_pkg::OP_BRANCH: begin
						o_ctrl.load_operands = 1'b1;
						state_next = cpu_pkg::ST_EXECUTE;
					end
					default: o_ctrl.pc_advance = 1'b1; // Unknown opcode skipped
				endcase
			end
			cpu_pkg::ST_EXECUTE: begin
				o_ctrl.load_result = 1'b1;
				o_ctrl.use_imm = (opcode != cpu_pkg::OP_ALU_R) && (opcode != cpu_pkg::OP_BRANCH);
				if (opcode == cpu_pkg::OP_LOAD || opcode == cpu_pkg::OP_STORE) begin
					o_ctrl.alu_op = cpu_pkg::ALU_ADD; // Address
					o_ctrl.load_store_data = (opcode == cpu_pkg::OP_STORE);
					state_next = cpu_pkg::ST_MEMORY;
				end else begin
					if (opcode == cpu_pkg::OP_BRANCH) begin
						o_ctrl.alu_op = cpu_pkg::ALU_SUB; // Only flags matter
					end
					state_next = cpu_pkg::ST_WRITEBACK;
				end
			end
			cpu_pkg::ST_MEMORY: begin
				if (opcode == cpu_pkg::OP_STORE) begin
					o_ldst_wr = 1'b1;
					o_ctrl.pc_advance = 1'b1;
				end else begin
					o_ldst_rd = 1'b1;
					state_next = cpu_pkg::ST_WRITEBACK;
				end
			end
			cpu_pkg::ST_WRITEBACK: begin
				o_ctrl.pc_advance = 1'b1;
				if (opcode == cpu_pkg::OP_BRANCH) begin
					o_branch_taken = cond_true;
				end else begin
					o_ctrl.rf_write = 1'b1;
					o_ctrl.wb_src = (opcode == cpu_pkg::OP_LOAD) ?
						cpu_pkg::WB_LOAD : cpu_pkg::WB_RESULT;
				end
			end
			default: state_next = cpu_pkg::ST_FETCH;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/cpu_top.sv ====
/*
 * Multicycle RV32I subset CPU
 * Control unit plus register file, execute unit and PC unit,
 * with one fetch port and one load/store port
 */
`default_nettype none

module cpu_top #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
)(
	input wire clk,
	input wire reset,

	output cpu_pkg::mem_req_t o_fetch_req,
	input wire cpu_pkg::word_t i_fetch_rdata,

	output cpu_pkg::mem_req_t o_ldst_req,
	input wire cpu_pkg::word_t i_ldst_rdata
);
	cpu_pkg::dp_ctrl_t ctrl;
	cpu_pkg::flags_t flags;
	cpu_pkg::word_t pc;
	cpu_pkg::word_t result; // Also the load/store address
	cpu_pkg::word_t op_a;
	cpu_pkg::word_t op_b;
	cpu_pkg::word_t store_data;
	cpu_pkg::word_t load_data;
	logic fetch_rd;
	logic ldst_rd;
	logic ldst_wr;
	logic branch_taken;

	cpu_control u_control (
		.clk(clk),
		.reset(reset),
		.i_fetch_rdata(i_fetch_rdata),
		.i_ldst_rdata(i_ldst_rdata),
		.i_flags(flags),
		.o_ctrl(ctrl),
		.o_fetch_rd(fetch_rd),
		.o_ldst_rd(ldst_rd),
		.o_ldst_wr(ldst_wr),
		.o_load_data(load_data),
		.o_branch_taken(branch_taken)
	);

	reg_file u_reg_file (
		.clk(clk),
		.reset(reset),
		.i_ctrl(ctrl),
		.i_result(result),
		.i_load_data(load_data),
		.o_op_a(op_a),
		.o_op_b(op_b)
	);

	execute_unit u_execute (
		.clk(clk),
		.reset(reset),
		.i_ctrl(ctrl),
		.i_op_a(op_a),
		.i_op_b(op_b),
		.o_result(result),
		.o_flags(flags),
		.o_store_data(store_data)
	);

	pc_unit #(.RESET_PC(RESET_PC)) u_pc (
		.clk(clk),
		.reset(reset),
		.i_ctrl(ctrl),
		.i_branch_taken(branch_taken),
		.o_pc(pc)
	);

	assign o_fetch_req = '{addr: pc, wdata: '0, rd: fetch_rd, wr: 1'b0}; // Read only port
	assign o_ldst_req = '{addr: result, wdata: store_data, rd: ldst_rd, wr: ldst_wr};

endmodule

`default_nettype wire

// ==== tb/cpu_checker.sv ====
/*
 * CPU checker
 * Follows the fetch stream, runs a reference model of each
 * instruction and compares stores and fetch addresses
 */
`default_nettype none

module cpu_checker #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
)(
	input wire clk,
	input wire reset,
	input wire cpu_pkg::mem_req_t i_fetch_req,
	input wire cpu_pkg::word_t i_fetch_rdata,
	input wire cpu_pkg::mem_req_t i_ldst_req,
	output logic o_done,
	output int o_errors
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int STEP_TIMEOUT = 50; // Cycles allowed for one strobe

	cpu_pkg::word_t ref_regs [32];
	cpu_pkg::word_t ref_mem [cpu_pkg::word_t];
	cpu_pkg::word_t ref_pc;
	int tests_run;
	int tests_failed;
	logic running;
	logic pending_branch;
	cpu_pkg::word_t branch_pc;

	function automatic cpu_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
		input cpu_pkg::word_t a, input cpu_pkg::word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? cpu_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic ref_branch(input logic [2:0] f3, input cpu_pkg::word_t a,
		input cpu_pkg::word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic wait_fetch(output logic found);
		int n;
		found = 1'b0;
		n = 0;
		while (!found && n < STEP_TIMEOUT) begin
			@(negedge clk);
			n++;
			if (i_ldst_req.rd || i_ldst_req.wr) begin
				$display("[ERROR] %0t: load/store strobe outside a load or store", $time);
				o_errors++;
			end
			if (i_fetch_req.wr !== 1'b0) begin
				$display("[ERROR] %0t: write strobe on the fetch port", $time);
				o_errors++;
			end
			found = i_fetch_req.rd;
		end
		if (!found) begin
			$display("Checker timed out waiting for a fetch strobe");
			o_errors++;
		end
	endtask

	task automatic wait_ldst(input logic is_write, output logic found);
		int n;
		found = 1'b0;
		n = 0;
		while (!found && n < STEP_TIMEOUT) begin
			@(negedge clk);
			n++;
			found = is_write ? i_ldst_req.wr : i_ldst_req.rd;
		end
		if (!found) begin
			$display("Checker timed out waiting for %s", is_write ? "store" : "load");
			o_errors++;
		end
	endtask

	task automatic write_reg(input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t v);
		if (rd != 0) begin // x0 stays zero
			ref_regs[rd] = v;
		end
	endtask

	task automatic run_instr(input cpu_pkg::word_t instr, output logic keep_going);
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		cpu_pkg::word_t addr;
		cpu_pkg::word_t imm_i;
		cpu_pkg::word_t imm_s;
		cpu_pkg::word_t imm_b;
		logic found;
		logic bad;
		a = ref_regs[instr[19:15]];
		b = ref_regs[instr[24:20]];
		imm_i = {{20{instr[31]}}, instr[31:20]};
		imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		keep_going = 1'b1;
		ref_pc = ref_pc + 4;
		case (instr[6:0])
			7'b0110111: write_reg(instr[11:7], {instr[31:12], 12'h000});
			7'b0110011: write_reg(instr[11:7], ref_alu(instr[14:12], instr[30], a, b));
			7'b0010011: write_reg(instr[11:7],
				ref_alu(instr[14:12], instr[14:12] == 3'd5 && instr[30], a, imm_i));
			7'b0000011: begin
				addr = a + imm_i;
				wait_ldst(1'b0, found);
				keep_going = found;
				if (found && i_ldst_req.addr !== addr) begin
					$display("[ERROR] %0t: load address %h, expected %h", $time,
						i_ldst_req.addr, addr);
					o_errors++;
				end
				write_reg(instr[11:7], ref_mem.exists(addr) ? ref_mem[addr] : '0);
			end
			7'b0100011: begin
				addr = a + imm_s;
				wait_ldst(1'b1, found);
				keep_going = found;
				if (found) begin
					bad = (i_ldst_req.addr !== addr) || (i_ldst_req.wdata !== b);
					if (bad) begin
						$display("[ERROR] %0t: store %h to %h, expected %h to %h", $time,
							i_ldst_req.wdata, i_ldst_req.addr, b, addr);
						o_errors++;
						tests_failed++;
					end
					ref_mem[addr] = b;
					tests_run++;
					$display("Test %0d store of %h to %h: %s", tests_run, b, addr,
						bad ? "FAIL" : "ok");
				end
			end
			7'b1100011: begin
				if (instr == 32'h0000_0063) begin
					keep_going = 1'b0; // Final self loop
				end else begin
					pending_branch = 1'b1;
					branch_pc = ref_pc - 4;
					if (ref_branch(instr[14:12], a, b)) begin
						ref_pc = branch_pc + imm_b;
					end
				end
			end
			default: ;
		endcase
	endtask

	initial begin
		int n;
		logic found;
		logic bad;
		o_done = 1'b0;
		o_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		pending_branch = 1'b0;
		ref_pc = RESET_PC;
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = '0;
		end
		n = 0;
		while (reset !== 1'b0 && n < 100) begin
			@(negedge clk);
			n++;
		end
		running = (reset === 1'b0);
		if (!running) begin
			$display("Checker timed out waiting for reset release");
			o_errors++;
		end
		while (running) begin
			wait_fetch(found);
			running = found;
			if (found) begin
				bad = (i_fetch_req.addr !== ref_pc);
				if (bad) begin
					$display("[ERROR] %0t: fetch from %h, expected %h", $time,
						i_fetch_req.addr, ref_pc);
					o_errors++;
				end
				if (pending_branch) begin
					pending_branch = 1'b0;
					tests_run++;
					tests_failed += bad;
					$display("Test %0d branch at %h: next fetch %h: %s", tests_run,
						branch_pc, ref_pc, bad ? "FAIL" : "ok");
				end
				@(negedge clk); // Instruction word is valid now
				run_instr(i_fetch_rdata, running);
			end
		end
		$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d", tests_run,
			tests_run - tests_failed, tests_failed, o_errors);
		if (tests_run == 0) begin
			$display("No test was run");
			o_errors++;
		end
		o_done = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/tb_cpu.sv ====
/*
 * CPU testbench top
 * Clock, reset, instruction and data memory models, a generated
 * test program and the checker that follows the run
 */
`default_nettype none

module tb_cpu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam cpu_pkg::word_t RESET_PC = 32'h0000_0100;
	localparam int IMEM_WORDS = 1024;
	localparam int DMEM_WORDS = 256;
	localparam int RUN_TIMEOUT = 20000; // Cycles for the whole program

	logic clk;
	logic reset;
	cpu_pkg::mem_req_t fetch_req;
	cpu_pkg::mem_req_t ldst_req;
	cpu_pkg::word_t fetch_rdata;
	cpu_pkg::word_t ldst_rdata;
	cpu_pkg::word_t imem [IMEM_WORDS];
	cpu_pkg::word_t dmem [DMEM_WORDS];
	logic [31:0] seed;
	int emit_idx;
	int store_cnt;
	logic done;
	int errors;
	int cycles;

	cpu_top #(.RESET_PC(RESET_PC)) uut (
		.clk(clk),
		.reset(reset),
		.o_fetch_req(fetch_req),
		.i_fetch_rdata(fetch_rdata),
		.o_ldst_req(ldst_req),
		.i_ldst_rdata(ldst_rdata)
	);

	cpu_checker #(.RESET_PC(RESET_PC)) u_checker (
		.clk(clk),
		.reset(reset),
		.i_fetch_req(fetch_req),
		.i_fetch_rdata(fetch_rdata),
		.i_ldst_req(ldst_req),
		.o_done(done),
		.o_errors(errors)
	);

	always #10 clk = ~clk;

	// Both memories answer one cycle after the strobe
	always @(posedge clk) begin
		if (fetch_req.rd) begin
			fetch_rdata <= imem[fetch_req.addr[11:2]];
		end
		if (ldst_req.rd) begin
			ldst_rdata <= dmem[ldst_req.addr[9:2]];
		end
		if (ldst_req.wr) begin
			dmem[ldst_req.addr[9:2]] <= ldst_req.wdata;
		end
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223; // LCG step
		return seed;
	endfunction

	function automatic cpu_pkg::word_t enc_r(input logic [2:0] f3, input logic alt,
		input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rs1,
		input cpu_pkg::reg_addr_t rs2);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, cpu_pkg::OP_ALU_R};
	endfunction

	function automatic cpu_pkg::word_t enc_i(input cpu_pkg::opcode_e op, input logic [2:0] f3,
		input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic cpu_pkg::word_t enc_s(input cpu_pkg::reg_addr_t rs2,
		input cpu_pkg::reg_addr_t rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::OP_STORE};
	endfunction

	function automatic cpu_pkg::word_t enc_b(input logic [2:0] f3, input cpu_pkg::reg_addr_t rs1,
		input cpu_pkg::reg_addr_t rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::OP_BRANCH};
	endfunction

	task automatic emit(input cpu_pkg::word_t w);
		imem[emit_idx] = w;
		emit_idx++;
	endtask

	// lui plus addi, with the upper part rounded for the sign of the low part
	task automatic load_const(input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t v);
		cpu_pkg::word_t hi;
		hi = (v + 32'h800) >> 12;
		emit({hi[19:0], rd, cpu_pkg::OP_LUI});
		emit(enc_i(cpu_pkg::OP_ALU_I, 3'b000, rd, rd, v[11:0]));
	endtask

	task automatic store_reg(input cpu_pkg::reg_addr_t rs);
		emit(enc_s(rs, 5'd0, 12'((store_cnt * 4) & 12'h3fc)));
		store_cnt++;
	endtask

	task automatic build_program();
		logic [2:0] r_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
		logic [2:0] i_f3 [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
		logic [2:0] b_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		logic [31:0] r;
		logic [11:0] imm;
		cpu_pkg::word_t a;
		emit_idx = RESET_PC[11:2];
		store_cnt = 0;
		for (int i = 0; i < 4; i++) begin // lui then sw
			r = next_rand();
			emit({r[19:0], 5'd5, cpu_pkg::OP_LUI});
			store_reg(5'd5);
		end
		for (int k = 0; k < 20; k++) begin // All ten register ops, twice
			load_const(5'd1, next_rand());
			load_const(5'd2, next_rand());
			emit(enc_r(r_f3[k % 10], (k % 10 == 1) || (k % 10 == 7), 5'd3, 5'd1, 5'd2));
			store_reg(5'd3);
		end
		for (int k = 0; k < 18; k++) begin
			load_const(5'd1, next_rand());
			r = next_rand();
			imm = r[11:0];
			if (k % 9 >= 6) begin
				imm = {(k % 9 == 8) ? 7'b0100000 : 7'b0, r[4:0]}; // Shift amount
			end
			emit(enc_i(cpu_pkg::OP_ALU_I, i_f3[k % 9], 5'd3, 5'd1, imm));
			store_reg(5'd3);
		end
		load_const(5'd1, next_rand()); // Store, load back, store again
		emit(enc_s(5'd1, 5'd0, 12'h3f0));
		emit(enc_i(cpu_pkg::OP_LOAD, 3'b010, 5'd4, 5'd0, 12'h3f0));
		store_reg(5'd4);
		emit(enc_i(cpu_pkg::OP_LOAD, 3'b010, 5'd0, 5'd0, 12'h3f0)); // Load into x0
		store_reg(5'd0);
		emit({20'habcde, 5'd0, cpu_pkg::OP_LUI});
		store_reg(5'd0);
		emit(enc_i(cpu_pkg::OP_ALU_I, 3'b000, 5'd6, 5'd0, 12'h000));
		for (int k = 0; k < 12; k++) begin
			a = next_rand();
			r = next_rand();
			load_const(5'd1, a);
			load_const(5'd2, (r[1:0] == 2'b00) ? a : next_rand());
			emit(enc_b(b_f3[r[7:2] % 6], 5'd1, 5'd2, r[8] ? 13'd8 : 13'd12));
			emit(enc_i(cpu_pkg::OP_ALU_I, 3'b000, 5'd6, 5'd6, 12'd1)); // Skipped when taken
			emit(enc_i(cpu_pkg::OP_ALU_I, 3'b000, 5'd6, 5'd6, 12'd2));
			store_reg(5'd6);
		end
		emit(enc_b(3'b000, 5'd0, 5'd0, 13'd0)); // Self loop ends the program
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		fetch_rdata = '0;
		ldst_rdata = '0;
		seed = 32'h35955589;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = '0;
		end
		build_program();
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		cycles = 0;
		while (!done && cycles < RUN_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (done && errors == 0) begin
			$display("Test completed successfully");
		end else begin
			if (!done) begin
				$display("Timed out waiting for the program to finish");
			end
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
hw/cpu_pkg.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/pc_unit.sv
hw/cpu_control.sv
hw/cpu_top.sv
tb/cpu_checker.sv
tb/tb_cpu.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_cpu
FILELIST = all.f
PASS_MSG = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
